/* hw/gcPkg.sv */
package gcPkg;

	// controller link frame sizes
	localparam int POLL_BITS = 24;
	localparam int REPLY_BITS = 64;
	localparam int HIT_BITS = 8;
	localparam int MIC_BITS = 12;
	localparam int INDEX_BITS = 7;

	typedef logic [REPLY_BITS-1:0] replyWord;
	typedef logic [POLL_BITS-1:0] pollWord;
	typedef logic [INDEX_BITS-1:0] bitIndex;
	typedef logic [MIC_BITS-1:0] micLevel;
	typedef logic [HIT_BITS-1:0] hitByte;

	// status poll with rumble off
	localparam pollWord POLL_COMMAND = 24'h400300;

	// hit readings above this come in doubled
	localparam hitByte HIT_HALVE_LIMIT = 8'h35;

	// link FSM
	typedef enum logic [1:0] {
		idle,
		sending,
		receiving
	} linkState;

endpackage

/* hw/displayPkg.sv */
package displayPkg;

	localparam int DIGIT_BITS = 4;
	localparam int SEG_BITS = 8;

	// one hex nibble per digit
	typedef logic [DIGIT_BITS-1:0] digit;

	// bit 7 decimal point, bits 6..0 are g..a, active high
	typedef logic [SEG_BITS-1:0] segments;

	localparam segments SEG_BLANK = 8'h00;

endpackage

/* hw/gcLink.sv */
`timescale 1ns/1ps

module gcLink #(
	parameter int CLKS_PER_QUARTER = 4,
	parameter int POLL_PERIOD = 3000
) (
	input logic clk,
	input logic rst,
	input logic pollSent,
	input logic replyValid,
	input logic edgeSeen,
	output logic quarterTick,
	output logic startPoll,
	output logic listen
);

	localparam int QW = $clog2(CLKS_PER_QUARTER + 1);
	localparam int PW = $clog2(POLL_PERIOD + 1);
	localparam int TIMEOUT_SLOTS = 32;

	logic [QW-1:0] quarterCnt;
	logic [PW-1:0] periodCnt;
	logic [5:0] quietSlots;
	gcPkg::linkState state;
	logic pollDue;
	logic timedOut;

	assign pollDue = (periodCnt == PW'(POLL_PERIOD - 1));
	assign timedOut = (quietSlots == 6'(TIMEOUT_SLOTS));
	assign listen = (state == gcPkg::receiving);

	// quarter-bit strobe, runs regardless of link state
	always_ff @(posedge clk) begin
		if (rst) begin
			quarterCnt <= '0;
			quarterTick <= 1'b0;
		end else if (quarterCnt == QW'(CLKS_PER_QUARTER - 1)) begin
			quarterCnt <= '0;
			quarterTick <= 1'b1;
		end else begin
			quarterCnt <= quarterCnt + 1'b1;
			quarterTick <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			periodCnt <= '0;
		end else if (pollDue) begin
			periodCnt <= '0;
		end else begin
			periodCnt <= periodCnt + 1'b1;
		end
	end

	// quarter slots since the last falling edge of the reply
	always_ff @(posedge clk) begin
		if (rst) begin
			quietSlots <= '0;
		end else if (!listen || edgeSeen) begin
			quietSlots <= '0;
		end else if (quarterTick && !timedOut) begin
			quietSlots <= quietSlots + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= gcPkg::idle;
			startPoll <= 1'b0;
		end else begin
			startPoll <= 1'b0;
			case (state)
				gcPkg::idle: begin
					// a poll that comes due while busy is dropped
					if (pollDue) begin
						startPoll <= 1'b1;
						state <= gcPkg::sending;
					end
				end
				gcPkg::sending: begin
					if (pollSent) begin
						state <= gcPkg::receiving;
					end
				end
				gcPkg::receiving: begin
					// no controller on the port ends up here via timeout
					if (replyValid || timedOut) begin
						state <= gcPkg::idle;
					end
				end
				default: begin
					state <= gcPkg::idle;
				end
			endcase
		end
	end

endmodule

/* hw/pollEncoder.sv */
`timescale 1ns/1ps

module pollEncoder #(
	parameter int CLKS_PER_QUARTER = 4
) (
	input logic clk,
	input logic rst,
	input logic startPoll,
	input logic quarterTick,
	output logic lineDrive,
	output logic pollSent
);

	localparam int TW = $clog2(CLKS_PER_QUARTER + 1);
	localparam gcPkg::bitIndex STOP_INDEX = gcPkg::bitIndex'(gcPkg::POLL_BITS);

	gcPkg::pollWord shiftReg;
	gcPkg::bitIndex bitIdx;
	logic [1:0] slot;
	logic busy;
	logic tail;
	logic [TW-1:0] tailCnt;
	logic bitVal;
	logic lowSlot;
	logic lastSlot;
	logic load;

	assign load = startPoll && !busy && !tail;

	// command bits msb first, then a stop bit of 1
	assign bitVal = (bitIdx < STOP_INDEX) ? shiftReg[gcPkg::POLL_BITS-1] : 1'b1;
	// slot 0 always low, slots 1 and 2 low only for a 0
	assign lowSlot = (slot == 2'd0) || (!bitVal && slot != 2'd3);
	assign lastSlot = (bitIdx == STOP_INDEX) && (slot == 2'd3);

	always_ff @(posedge clk) begin
		if (load) begin
			shiftReg <= gcPkg::POLL_COMMAND;
		end else if (busy && quarterTick && slot == 2'd3) begin
			shiftReg <= shiftReg << 1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			tail <= 1'b0;
			tailCnt <= '0;
			slot <= 2'd0;
			bitIdx <= '0;
			lineDrive <= 1'b0;
			pollSent <= 1'b0;
		end else begin
			pollSent <= 1'b0;
			if (load) begin
				busy <= 1'b1;
				slot <= 2'd0;
				bitIdx <= '0;
			end else if (busy && quarterTick) begin
				lineDrive <= lowSlot;
				slot <= slot + 2'd1;
				if (slot == 2'd3) begin
					bitIdx <= bitIdx + 1'b1;
				end
				if (lastSlot) begin
					busy <= 1'b0;
					tail <= 1'b1;
					tailCnt <= TW'(CLKS_PER_QUARTER - 1);
				end
			end else if (tail) begin
				// wait out the high slot that ends the stop bit
				if (tailCnt == '0) begin
					tail <= 1'b0;
					pollSent <= 1'b1;
				end else begin
					tailCnt <= tailCnt - 1'b1;
				end
			end
		end
	end

endmodule

/* hw/replyDecoder.sv */
`timescale 1ns/1ps

module replyDecoder #(
	parameter int CLKS_PER_QUARTER = 4
) (
	input logic clk,
	input logic rst,
	input logic lineIn,
	input logic listen,
	output logic edgeSeen,
	output logic replyValid,
	output gcPkg::replyWord replyData
);

	localparam int LW = $clog2(4 * CLKS_PER_QUARTER) + 1;
	localparam int ONE_LIMIT = 2 * CLKS_PER_QUARTER;
	localparam gcPkg::bitIndex LAST_INDEX = gcPkg::bitIndex'(gcPkg::REPLY_BITS - 1);
	localparam gcPkg::bitIndex DONE_INDEX = gcPkg::bitIndex'(gcPkg::REPLY_BITS);

	logic [1:0] lineSync;
	logic linePrev;
	logic fall;
	logic rise;
	logic [LW-1:0] lowCnt;
	gcPkg::bitIndex bitCnt;
	gcPkg::replyWord shiftReg;
	logic rxBit;
	logic frameDone;
	logic takeBit;

	assign fall = linePrev && !lineSync[1];
	assign rise = !linePrev && lineSync[1];
	assign edgeSeen = fall;
	// short low pulse means 1
	assign rxBit = (lowCnt < LW'(ONE_LIMIT));
	// the stop bit after bit 0 is not shifted in
	assign frameDone = (bitCnt == DONE_INDEX);
	assign takeBit = listen && rise && !frameDone;
	assign replyData = shiftReg;

	// wire idles high through the pull-up
	always_ff @(posedge clk) begin
		if (rst) begin
			lineSync <= 2'b11;
			linePrev <= 1'b1;
		end else begin
			lineSync <= {lineSync[0], lineIn};
			linePrev <= lineSync[1];
		end
	end

	// low time in clk cycles, saturating
	always_ff @(posedge clk) begin
		if (rst) begin
			lowCnt <= '0;
		end else if (fall) begin
			lowCnt <= LW'(1);
		end else if (!lineSync[1] && lowCnt != '1) begin
			lowCnt <= lowCnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (takeBit) begin
			shiftReg <= {shiftReg[gcPkg::REPLY_BITS-2:0], rxBit};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bitCnt <= '0;
			replyValid <= 1'b0;
		end else if (!listen) begin
			bitCnt <= '0;
			replyValid <= 1'b0;
		end else begin
			replyValid <= 1'b0;
			if (takeBit) begin
				bitCnt <= bitCnt + 1'b1;
				if (bitCnt == LAST_INDEX) begin
					replyValid <= 1'b1;
				end
			end
		end
	end

endmodule

/* hw/bongoDisplay.sv */
`timescale 1ns/1ps

module bongoDisplay (
	input logic clk,
	input logic rst,
	input logic replyValid,
	input gcPkg::replyWord replyData,
	output gcPkg::hitByte hit,
	output gcPkg::micLevel mic,
	output logic frameValid,
	output displayPkg::digit dig1,
	output displayPkg::digit dig0,
	output displayPkg::segments seg1,
	output displayPkg::segments seg0
);

	gcPkg::hitByte rawHit;
	gcPkg::hitByte scaledHit;

	// hex to g..a, decimal point left off
	function automatic displayPkg::segments hexSeg(input displayPkg::digit d);
		hexSeg = displayPkg::SEG_BLANK;
		case (d)
			4'h0: hexSeg[6:0] = 7'h3F;
			4'h1: hexSeg[6:0] = 7'h06;
			4'h2: hexSeg[6:0] = 7'h5B;
			4'h3: hexSeg[6:0] = 7'h4F;
			4'h4: hexSeg[6:0] = 7'h66;
			4'h5: hexSeg[6:0] = 7'h6D;
			4'h6: hexSeg[6:0] = 7'h7D;
			4'h7: hexSeg[6:0] = 7'h07;
			4'h8: hexSeg[6:0] = 7'h7F;
			4'h9: hexSeg[6:0] = 7'h6F;
			4'hA: hexSeg[6:0] = 7'h77;
			4'hB: hexSeg[6:0] = 7'h7C;
			4'hC: hexSeg[6:0] = 7'h39;
			4'hD: hexSeg[6:0] = 7'h5E;
			4'hE: hexSeg[6:0] = 7'h79;
			default: hexSeg[6:0] = 7'h71;
		endcase
	endfunction

	assign rawHit = replyData[gcPkg::REPLY_BITS-1 -: gcPkg::HIT_BITS];
	assign scaledHit = (rawHit > gcPkg::HIT_HALVE_LIMIT) ? (rawHit >> 1) : rawHit;

	always_ff @(posedge clk) begin
		if (rst) begin
			hit <= '0;
			mic <= '0;
			frameValid <= 1'b0;
			dig1 <= '0;
			dig0 <= '0;
			seg1 <= hexSeg(4'h0);
			seg0 <= hexSeg(4'h0);
		end else begin
			frameValid <= replyValid;
			if (replyValid) begin
				hit <= scaledHit;
				mic <= replyData[gcPkg::MIC_BITS-1:0];
				dig1 <= scaledHit[7:4];
				dig0 <= scaledHit[3:0];
				seg1 <= hexSeg(scaledHit[7:4]);
				seg0 <= hexSeg(scaledHit[3:0]);
			end
		end
	end

endmodule

/* hw/bongoReader.sv */
`timescale 1ns/1ps

module bongoReader #(
	parameter int CLKS_PER_QUARTER = 4,
	parameter int POLL_PERIOD = 3000
) (
	input logic clk,
	input logic rst,
	input logic lineIn,
	output logic lineDrive,
	output logic frameValid,
	output gcPkg::hitByte hit,
	output gcPkg::micLevel mic,
	output displayPkg::digit dig1,
	output displayPkg::digit dig0,
	output displayPkg::segments seg1,
	output displayPkg::segments seg0
);

	logic quarterTick;
	logic startPoll;
	logic listen;
	logic pollSent;
	logic edgeSeen;
	logic replyValid;
	gcPkg::replyWord replyData;

	gcLink #(
		.CLKS_PER_QUARTER(CLKS_PER_QUARTER),
		.POLL_PERIOD(POLL_PERIOD)
	) u_gcLink (
		.clk(clk),
		.rst(rst),
		.pollSent(pollSent),
		.replyValid(replyValid),
		.edgeSeen(edgeSeen),
		.quarterTick(quarterTick),
		.startPoll(startPoll),
		.listen(listen)
	);

	pollEncoder #(
		.CLKS_PER_QUARTER(CLKS_PER_QUARTER)
	) u_pollEncoder (
		.clk(clk),
		.rst(rst),
		.startPoll(startPoll),
		.quarterTick(quarterTick),
		.lineDrive(lineDrive),
		.pollSent(pollSent)
	);

	replyDecoder #(
		.CLKS_PER_QUARTER(CLKS_PER_QUARTER)
	) u_replyDecoder (
		.clk(clk),
		.rst(rst),
		.lineIn(lineIn),
		.listen(listen),
		.edgeSeen(edgeSeen),
		.replyValid(replyValid),
		.replyData(replyData)
	);

	bongoDisplay u_bongoDisplay (
		.clk(clk),
		.rst(rst),
		.replyValid(replyValid),
		.replyData(replyData),
		.hit(hit),
		.mic(mic),
		.frameValid(frameValid),
		.dig1(dig1),
		.dig0(dig0),
		.seg1(seg1),
		.seg0(seg0)
	);

endmodule

/* testbench/bongoChecker.sv */
`timescale 1ns/1ps

module bongoChecker #(
	parameter int CLKS_PER_QUARTER = 4,
	parameter int TOTAL_POLLS = 11
) (
	input logic clk,
	input logic rst,
	input logic lineDrive,
	input logic frameValid,
	input gcPkg::hitByte hit,
	input gcPkg::micLevel mic,
	input displayPkg::digit dig1,
	input displayPkg::digit dig0,
	input displayPkg::segments seg1,
	input displayPkg::segments seg0,
	input logic sentStrobe,
	input logic sentSkip,
	input gcPkg::replyWord sentWord,
	output logic allDone,
	output int failCount
);

	// 24 command bits msb first, then the stop bit
	localparam logic [24:0] POLL_FRAME = {24'h400300, 1'b1};
	localparam logic [7:0] HALVE_ABOVE = 8'h35;

	// skip flag on top of the word the controller sent
	logic [64:0] sentQ[$];
	int passCount;
	int replyCount;
	int pollCount;
	int pulseWidth;
	int pulseCount;
	logic [24:0] pollBits;
	logic prevDrive;
	logic resetChecked;
	// hit value the display should be showing
	logic [7:0] shownHit;

	// g..a for each hex digit, decimal point off
	function automatic logic [7:0] hexToSeg(input logic [3:0] n);
		case (n)
			4'h0: return 8'h3F;
			4'h1: return 8'h06;
			4'h2: return 8'h5B;
			4'h3: return 8'h4F;
			4'h4: return 8'h66;
			4'h5: return 8'h6D;
			4'h6: return 8'h7D;
			4'h7: return 8'h07;
			4'h8: return 8'h7F;
			4'h9: return 8'h6F;
			4'hA: return 8'h77;
			4'hB: return 8'h7C;
			4'hC: return 8'h39;
			4'hD: return 8'h5E;
			4'hE: return 8'h79;
			default: return 8'h71;
		endcase
	endfunction

	task automatic compareValue(input string what, input logic [63:0] got,
			input logic [63:0] want, inout int errs);
		if (got !== want) begin
			errs++;
			$display("Fail %0t: %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	task automatic finishTest(input string name, input int errs);
		if (errs == 0) begin
			passCount++;
			$display("%s: ok", name);
		end else begin
			failCount++;
			$display("%s: %0d mismatches", name, errs);
		end
	endtask

	task automatic checkReset;
		int errs = 0;
		compareValue("lineDrive after reset", 64'(lineDrive), 64'(0), errs);
		compareValue("frameValid after reset", 64'(frameValid), 64'(0), errs);
		compareValue("dig1 after reset", 64'(dig1), 64'(0), errs);
		compareValue("dig0 after reset", 64'(dig0), 64'(0), errs);
		compareValue("seg1 after reset", 64'(seg1), 64'(hexToSeg(4'h0)), errs);
		compareValue("seg0 after reset", 64'(seg0), 64'(hexToSeg(4'h0)), errs);
		shownHit = 8'h00;
		finishTest("reset state", errs);
	endtask

	task automatic checkCommand;
		int errs = 0;
		compareValue($sformatf("poll %0d command", pollCount), 64'(pollBits),
			64'(POLL_FRAME), errs);
		finishTest($sformatf("poll %0d command", pollCount), errs);
		pollCount++;
	endtask

	task automatic checkFrame;
		int errs = 0;
		logic [64:0] entry;
		logic [7:0] want;
		if (sentQ.size() == 0) begin
			failCount++;
			$display("frameValid at %0t came before any reply was sent", $time);
		end else begin
			entry = sentQ.pop_front();
			if (entry[64]) begin
				$display("frameValid at %0t while the controller stayed silent", $time);
				finishTest("silent poll", 1);
			end else begin
				want = entry[63:56];
				if (want > HALVE_ABOVE) begin
					want = want >> 1;
				end
				compareValue("mic", 64'(mic), 64'(entry[11:0]), errs);
				compareValue("hit", 64'(hit), 64'(want), errs);
				compareValue("dig1", 64'(dig1), 64'(want[7:4]), errs);
				compareValue("dig0", 64'(dig0), 64'(want[3:0]), errs);
				compareValue("seg1", 64'(seg1), 64'(hexToSeg(want[7:4])), errs);
				compareValue("seg0", 64'(seg0), 64'(hexToSeg(want[3:0])), errs);
				shownHit = want;
				finishTest($sformatf("reply %0d", replyCount), errs);
			end
			replyCount++;
		end
	endtask

	// a new poll starting means the previous one is over
	task automatic checkSilence;
		int errs = 0;
		logic [64:0] entry;
		if (sentQ.size() != 0) begin
			entry = sentQ.pop_front();
			if (entry[64]) begin
				compareValue("hit after silent poll", 64'(hit), 64'(shownHit), errs);
				compareValue("dig1 after silent poll", 64'(dig1), 64'(shownHit[7:4]), errs);
				compareValue("dig0 after silent poll", 64'(dig0), 64'(shownHit[3:0]), errs);
				compareValue("seg1 after silent poll", 64'(seg1),
					64'(hexToSeg(shownHit[7:4])), errs);
				compareValue("seg0 after silent poll", 64'(seg0),
					64'(hexToSeg(shownHit[3:0])), errs);
				finishTest("silent poll", errs);
			end else begin
				$display("reply %0d never produced frameValid", replyCount);
				finishTest($sformatf("reply %0d", replyCount), 1);
			end
			replyCount++;
		end
	endtask

	// outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clk) begin
		if (rst) begin
			allDone = 1'b0;
			failCount = 0;
			passCount = 0;
			replyCount = 0;
			pollCount = 0;
			pulseWidth = 0;
			pulseCount = 0;
			prevDrive = 1'b0;
			resetChecked = 1'b0;
		end else begin
			if (!resetChecked) begin
				checkReset();
				resetChecked = 1'b1;
			end
			if (sentStrobe) begin
				sentQ.push_back({sentSkip, sentWord});
			end
			if (lineDrive) begin
				if (!prevDrive && pulseCount == 0) begin
					checkSilence();
				end
				pulseWidth++;
			end else if (prevDrive) begin
				// one low slot is a 1, three are a 0
				pollBits = {pollBits[23:0], pulseWidth < 2 * CLKS_PER_QUARTER};
				pulseWidth = 0;
				pulseCount++;
				if (pulseCount == 25) begin
					checkCommand();
					pulseCount = 0;
				end
			end
			prevDrive = lineDrive;
			if (frameValid) begin
				checkFrame();
			end
			if (!allDone && replyCount >= TOTAL_POLLS) begin
				allDone = 1'b1;
				$display("checks: %0d ok, %0d bad", passCount, failCount);
			end
		end
	end

endmodule

/* testbench/tb.sv */
`timescale 1ns/1ps

module tb;

	localparam int CLKS_PER_QUARTER = 4;
	localparam int POLL_PERIOD = 3000;
	localparam int TOTAL_POLLS = 11;
	localparam int SILENT_POLL = 4;
	localparam int CYCLE_LIMIT = 12 * POLL_PERIOD + 1000;
	// rest of the stop bit, then six slots of turnaround
	localparam int ANSWER_DELAY = 9 * CLKS_PER_QUARTER;

	logic clk;
	logic rst;
	logic lineIn;
	logic ctrlDrive;
	logic lineDrive;
	logic frameValid;
	gcPkg::hitByte hit;
	gcPkg::micLevel mic;
	displayPkg::digit dig1;
	displayPkg::digit dig0;
	displayPkg::segments seg1;
	displayPkg::segments seg0;
	logic sentStrobe;
	logic sentSkip;
	gcPkg::replyWord sentWord;
	logic allDone;
	int failCount;
	logic [63:0] rngState;
	int cycles;

	// open-drain wire with pull-up
	assign lineIn = !(lineDrive === 1'b1) && !ctrlDrive;

	function automatic logic [63:0] nextRandom(input logic [63:0] s);
		logic [63:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 7);
		x = x ^ (x << 17);
		return x;
	endfunction

	// ends 1 ns after a rising edge
	task automatic waitCycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// four quarter slots, low pulse first
	task automatic sendBit(input logic b);
		for (int slot = 0; slot < 4; slot++) begin
			ctrlDrive = (slot == 0) || (!b && slot != 3);
			waitCycles(CLKS_PER_QUARTER);
		end
	endtask

	bongoReader #(
		.CLKS_PER_QUARTER(CLKS_PER_QUARTER),
		.POLL_PERIOD(POLL_PERIOD)
	) u_bongoReader (
		.clk(clk),
		.rst(rst),
		.lineIn(lineIn),
		.lineDrive(lineDrive),
		.frameValid(frameValid),
		.hit(hit),
		.mic(mic),
		.dig1(dig1),
		.dig0(dig0),
		.seg1(seg1),
		.seg0(seg0)
	);

	bongoChecker #(
		.CLKS_PER_QUARTER(CLKS_PER_QUARTER),
		.TOTAL_POLLS(TOTAL_POLLS)
	) u_bongoChecker (
		.clk(clk),
		.rst(rst),
		.lineDrive(lineDrive),
		.frameValid(frameValid),
		.hit(hit),
		.mic(mic),
		.dig1(dig1),
		.dig0(dig0),
		.seg1(seg1),
		.seg0(seg0),
		.sentStrobe(sentStrobe),
		.sentSkip(sentSkip),
		.sentWord(sentWord),
		.allDone(allDone),
		.failCount(failCount)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// controller model, answers every poll except the silent one
	initial begin : controllerModel
		gcPkg::replyWord word;
		ctrlDrive = 1'b0;
		sentStrobe = 1'b0;
		sentSkip = 1'b0;
		sentWord = '0;
		rngState = 64'd30580;
		wait (rst === 1'b0);
		for (int poll = 0; poll < TOTAL_POLLS; poll++) begin
			// command bits and stop bit all start low
			repeat (25) @(negedge lineDrive);
			waitCycles(1);
			rngState = nextRandom(rngState);
			word = rngState;
			// hit bytes on both sides of the halving limit
			case (poll)
				0: word[63:56] = 8'h35;
				1: word[63:56] = 8'h36;
				2: word[63:56] = {3'b000, word[60:56]};
				default: ;
			endcase
			sentWord = word;
			sentSkip = (poll == SILENT_POLL);
			sentStrobe = 1'b1;
			waitCycles(1);
			sentStrobe = 1'b0;
			waitCycles(ANSWER_DELAY - 2);
			if (poll != SILENT_POLL) begin
				for (int i = 63; i >= 0; i--) begin
					sendBit(word[i]);
				end
				sendBit(1'b1);
			end
		end
	end

	initial begin
		rst = 1'b1;
		cycles = 0;
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;
		while (allDone !== 1'b1 && cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (allDone === 1'b1 && failCount == 0) begin
			$display("test passed");
		end else begin
			if (allDone !== 1'b1) begin
				$display("run stopped at the limit of %0d cycles before all polls were checked",
					cycles);
			end
			$display("test failed");
		end
		$finish;
	end

endmodule

/* list.f */
hw/gcPkg.sv
hw/displayPkg.sv
hw/gcLink.sv
hw/pollEncoder.sv
hw/replyDecoder.sv
hw/bongoDisplay.sv
hw/bongoReader.sv
testbench/bongoChecker.sv
testbench/tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb -f list.f -o simTb
./obj_dir/simTb | tee sim.log

if grep -q "test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failures"
